/* common/cpu16_pkg.sv */
// cpu16 shared types and constants
`default_nettype none

package cpu16_pkg;

   localparam int WORD_W    = 16;   // datapath width
   localparam int REG_IDX_W = 4;    // register index width
   localparam int OP_W      = 4;    // opcode field width
   localparam int NUM_REGS  = 16;   // architectural registers
   localparam int IMM8_LSB  = 0;    // imm8 sits in the low byte of the instruction
   localparam int IMM8_W    = 8;    // LLB/LHB immediate width
   localparam int SHAMT_W   = 4;    // shift amount width
   localparam int INC_IMM_W = 4;    // INC immediate width before sign extension

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [OP_W-1:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_NAND = 4'd2,
      OP_XOR  = 4'd3,
      OP_INC  = 4'd4,
      OP_SRA  = 4'd5,
      OP_SRL  = 4'd6,
      OP_SLL  = 4'd7,
      OP_LLB  = 4'd8,
      OP_LHB  = 4'd9,
      OP_NOP  = 4'd10   // 10 and everything above it
   } opcode_t;

   typedef struct packed {
      logic z;   // zero
      logic v;   // signed overflow
      logic n;   // negative
   } flags_t;

   typedef struct packed {
      opcode_t  op;   // [15:12]
      reg_idx_t rd;   // [11:8]
      reg_idx_t rs;   // [7:4]
      reg_idx_t rt;   // [3:0]
   } instr_t;

   // ALU ops plus the two byte loads write back
   function automatic logic op_writes_reg(input opcode_t op);
      return (op < OP_NOP);
   endfunction

   // only ADD SUB NAND XOR INC touch the flags
   function automatic logic op_sets_flags(input opcode_t op);
      return (op <= OP_INC);
   endfunction

endpackage

`default_nettype wire

/* common/pipe_if.sv */
// pipeline stage bundles
`default_nettype none

// decode to execute
interface issue_if;
   logic                          valid;   // instruction present
   cpu16_pkg::opcode_t            op;
   cpu16_pkg::reg_idx_t           rd;      // destination
   cpu16_pkg::word_t              a;       // rs value
   cpu16_pkg::word_t              b;       // rt value or old rd for byte loads
   logic [cpu16_pkg::IMM8_W-1:0]  imm8;    // low instruction byte

   modport decode  (output valid, op, rd, a, b, imm8);
   modport execute (input  valid, op, rd, a, b, imm8);
endinterface

// execute to writeback
interface retire_if;
   logic                 valid;      // instruction present
   cpu16_pkg::reg_idx_t  rd;
   cpu16_pkg::word_t     value;      // alu result
   logic                 wr_reg;     // register write pending
   logic                 wr_flags;   // flag update pending
   cpu16_pkg::flags_t    flags;      // new z v n

   modport execute   (output valid, rd, value, wr_reg, wr_flags, flags);
   modport writeback (input  valid, rd, value, wr_reg, wr_flags, flags);
   modport bypass    (input  valid, rd, value, wr_reg);   // decode forwarding
endinterface

`default_nettype wire

/* hw/reg_file.sv */
// register file
`default_nettype none

module reg_file (
   input  logic                clk,
   input  logic                reset,
   input  cpu16_pkg::reg_idx_t raddr_a,
   input  cpu16_pkg::reg_idx_t raddr_b,
   input  cpu16_pkg::reg_idx_t raddr_c,
   output cpu16_pkg::word_t    rdata_a,
   output cpu16_pkg::word_t    rdata_b,
   output cpu16_pkg::word_t    rdata_c,
   input  logic                we,
   input  cpu16_pkg::reg_idx_t waddr,
   input  cpu16_pkg::word_t    wdata
);

   cpu16_pkg::word_t regs [cpu16_pkg::NUM_REGS];   // r0 never written

   // synchronous write port
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < cpu16_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;   // all registers cleared
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;   // r0 writes dropped
      end
   end

   // asynchronous reads, r0 hardwired
   assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];   // rs port
   assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];   // rt port
   assign rdata_c = (raddr_c == '0) ? '0 : regs[raddr_c];   // rd port for byte loads

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
// decode and operand forwarding
`default_nettype none

module decode_stage (
   input  logic                clk,
   input  logic                reset,
   input  logic                instr_valid,
   input  cpu16_pkg::instr_t   instr,
   output cpu16_pkg::reg_idx_t rf_raddr_a,
   output cpu16_pkg::reg_idx_t rf_raddr_b,
   output cpu16_pkg::reg_idx_t rf_raddr_c,
   input  cpu16_pkg::word_t    rf_rdata_a,
   input  cpu16_pkg::word_t    rf_rdata_b,
   input  cpu16_pkg::word_t    rf_rdata_c,
   input  logic                ex_fwd_valid,
   input  cpu16_pkg::reg_idx_t ex_fwd_rd,
   input  cpu16_pkg::word_t    ex_fwd_value,
   retire_if.bypass            retire,
   issue_if.decode             issue
);

   logic                         ret_fwd_valid;   // retire reg holds a register write
   logic                         is_load_byte;    // LLB or LHB
   cpu16_pkg::word_t             opnd_a;          // resolved rs
   cpu16_pkg::word_t             opnd_b;          // resolved rt
   cpu16_pkg::word_t             opnd_c;          // resolved rd
   cpu16_pkg::word_t             b_sel;
   logic [cpu16_pkg::IMM8_W-1:0] imm8;

   // younger producer first, then retire, then the array
   function automatic cpu16_pkg::word_t pick_operand(
      input cpu16_pkg::reg_idx_t src,
      input cpu16_pkg::word_t    rf_val,
      input logic                ex_ok,
      input cpu16_pkg::reg_idx_t ex_rd,
      input cpu16_pkg::word_t    ex_val,
      input logic                rt_ok,
      input cpu16_pkg::reg_idx_t rt_rd,
      input cpu16_pkg::word_t    rt_val
   );
      if (ex_ok && (src != '0) && (ex_rd == src)) begin
         return ex_val;   // distance one
      end else if (rt_ok && (src != '0) && (rt_rd == src)) begin
         return rt_val;   // distance two
      end else begin
         return rf_val;   // already written
      end
   endfunction

   assign rf_raddr_a = instr.rs;
   assign rf_raddr_b = instr.rt;
   assign rf_raddr_c = instr.rd;   // old value for byte merge

   assign ret_fwd_valid = retire.valid & retire.wr_reg;
   assign is_load_byte  = (instr.op == cpu16_pkg::OP_LLB) || (instr.op == cpu16_pkg::OP_LHB);
   assign imm8          = instr[cpu16_pkg::IMM8_LSB +: cpu16_pkg::IMM8_W];

   always_comb begin
      opnd_a = pick_operand(instr.rs, rf_rdata_a, ex_fwd_valid, ex_fwd_rd, ex_fwd_value,
                            ret_fwd_valid, retire.rd, retire.value);
      opnd_b = pick_operand(instr.rt, rf_rdata_b, ex_fwd_valid, ex_fwd_rd, ex_fwd_value,
                            ret_fwd_valid, retire.rd, retire.value);
      opnd_c = pick_operand(instr.rd, rf_rdata_c, ex_fwd_valid, ex_fwd_rd, ex_fwd_value,
                            ret_fwd_valid, retire.rd, retire.value);
      b_sel  = is_load_byte ? opnd_c : opnd_b;   // byte loads merge into rd
   end

   // issue register valid bit
   always_ff @(posedge clk) begin
      if (reset) begin
         issue.valid <= 1'b0;
      end else begin
         issue.valid <= instr_valid;   // bubble when nothing accepted
      end
   end

   // issue payload, loaded only on accept
   always_ff @(posedge clk) begin
      if (instr_valid) begin
         issue.op   <= instr.op;
         issue.rd   <= instr.rd;
         issue.a    <= opnd_a;
         issue.b    <= b_sel;
         issue.imm8 <= imm8;
      end
   end

endmodule

`default_nettype wire

/* execute/alu.sv */
// 16-bit ALU
`default_nettype none

module alu (
   input  cpu16_pkg::opcode_t           op,
   input  cpu16_pkg::word_t             a,
   input  cpu16_pkg::word_t             b,
   input  logic [cpu16_pkg::IMM8_W-1:0] imm8,
   input  cpu16_pkg::flags_t            flags_in,
   output cpu16_pkg::word_t             result,
   output cpu16_pkg::flags_t            flags_out
);

   logic [cpu16_pkg::SHAMT_W-1:0] shamt;     // shift amount
   cpu16_pkg::word_t              inc_imm;   // sign-extended INC immediate
   cpu16_pkg::word_t              sum;
   cpu16_pkg::word_t              diff;
   cpu16_pkg::word_t              sum_inc;
   logic                          ovf_add;
   logic                          ovf_sub;
   logic                          ovf_inc;
   logic                          ovf;       // selected overflow

   assign shamt   = imm8[cpu16_pkg::SHAMT_W-1:0];
   assign inc_imm = {{(cpu16_pkg::WORD_W - cpu16_pkg::INC_IMM_W){imm8[cpu16_pkg::INC_IMM_W-1]}},
                     imm8[cpu16_pkg::INC_IMM_W-1:0]};

   assign sum     = a + b;
   assign diff    = a - b;
   assign sum_inc = a + inc_imm;

   // signed overflow, not carry out
   assign ovf_add = (a[cpu16_pkg::WORD_W-1] == b[cpu16_pkg::WORD_W-1]) &&
                    (sum[cpu16_pkg::WORD_W-1] != a[cpu16_pkg::WORD_W-1]);   // like signs
   assign ovf_sub = (a[cpu16_pkg::WORD_W-1] != b[cpu16_pkg::WORD_W-1]) &&
                    (diff[cpu16_pkg::WORD_W-1] != a[cpu16_pkg::WORD_W-1]);  // unlike signs
   assign ovf_inc = (a[cpu16_pkg::WORD_W-1] == inc_imm[cpu16_pkg::WORD_W-1]) &&
                    (sum_inc[cpu16_pkg::WORD_W-1] != a[cpu16_pkg::WORD_W-1]);

   always_comb begin
      result = '0;
      ovf    = 1'b0;   // logic ops clear V
      case (op)
         cpu16_pkg::OP_ADD: begin
            result = sum;
            ovf    = ovf_add;
         end
         cpu16_pkg::OP_SUB: begin
            result = diff;
            ovf    = ovf_sub;
         end
         cpu16_pkg::OP_NAND: result = ~(a & b);   // true complement of AND
         cpu16_pkg::OP_XOR:  result = a ^ b;
         cpu16_pkg::OP_INC: begin
            result = sum_inc;
            ovf    = ovf_inc;
         end
         cpu16_pkg::OP_SRA: result = $signed(a) >>> shamt;   // sign fill
         cpu16_pkg::OP_SRL: result = a >> shamt;             // zero fill
         cpu16_pkg::OP_SLL: result = a << shamt;
         cpu16_pkg::OP_LLB: result = {b[15:8], imm8};        // keep high byte
         cpu16_pkg::OP_LHB: result = {imm8, b[7:0]};         // keep low byte
         default:           result = '0;                     // no-op, never written
      endcase

      flags_out = flags_in;   // shifts, loads, no-ops hold
      if (cpu16_pkg::op_sets_flags(op)) begin
         flags_out.z = (result == '0);
         flags_out.v = ovf;
         flags_out.n = result[cpu16_pkg::WORD_W-1];
      end
   end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
// execute stage
`default_nettype none

module execute_stage (
   input  logic                clk,
   input  logic                reset,
   issue_if.execute            issue,
   input  cpu16_pkg::flags_t   flags_cur,
   output logic                ex_fwd_valid,
   output cpu16_pkg::reg_idx_t ex_fwd_rd,
   output cpu16_pkg::word_t    ex_fwd_value,
   retire_if.execute           retire
);

   cpu16_pkg::word_t  alu_result;
   cpu16_pkg::flags_t alu_flags;
   logic              writes_reg;   // opcode class
   logic              sets_flags;

   alu u_alu (
      .op        (issue.op),
      .a         (issue.a),
      .b         (issue.b),
      .imm8      (issue.imm8),
      .flags_in  (flags_cur),   // committed flags
      .result    (alu_result),
      .flags_out (alu_flags)
   );

   assign writes_reg = cpu16_pkg::op_writes_reg(issue.op);
   assign sets_flags = cpu16_pkg::op_sets_flags(issue.op);

   // forwarding tap straight off the ALU
   assign ex_fwd_valid = issue.valid & writes_reg;
   assign ex_fwd_rd    = issue.rd;
   assign ex_fwd_value = alu_result;

   // retire control
   always_ff @(posedge clk) begin
      if (reset) begin
         retire.valid    <= 1'b0;
         retire.wr_reg   <= 1'b0;
         retire.wr_flags <= 1'b0;
      end else begin
         retire.valid    <= issue.valid;
         retire.wr_reg   <= writes_reg;   // no-ops never write
         retire.wr_flags <= sets_flags;   // qualified by valid downstream
      end
   end

   // retire payload
   always_ff @(posedge clk) begin
      retire.rd    <= issue.rd;
      retire.value <= alu_result;
      retire.flags <= alu_flags;
   end

endmodule

`default_nettype wire

/* hw/writeback_stage.sv */
// writeback stage
`default_nettype none

module writeback_stage (
   input  logic                clk,
   input  logic                reset,
   retire_if.writeback         retire,
   output logic                rf_we,
   output cpu16_pkg::reg_idx_t rf_waddr,
   output cpu16_pkg::word_t    rf_wdata,
   output cpu16_pkg::flags_t   flags,
   output logic                wb_valid,
   output cpu16_pkg::reg_idx_t wb_rd,
   output cpu16_pkg::word_t    wb_data
);

   logic flags_we;   // flag register load

   // register file write port
   assign rf_we    = retire.valid & retire.wr_reg;   // r0 dropped inside the array
   assign rf_waddr = retire.rd;
   assign rf_wdata = retire.value;

   assign flags_we = retire.valid & retire.wr_flags;

   // flag register and writeback strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         flags    <= '0;
         wb_valid <= 1'b0;
      end else begin
         if (flags_we) begin
            flags <= retire.flags;   // z v n update
         end
         wb_valid <= rf_we;   // one cycle per write
      end
   end

   // writeback payload
   always_ff @(posedge clk) begin
      if (rf_we) begin
         wb_rd   <= retire.rd;
         wb_data <= retire.value;
      end
   end

endmodule

`default_nettype wire

/* hw/cpu16_core.sv */
// cpu16 pipeline top
`default_nettype none

module cpu16_core (
   input  logic                clk,
   input  logic                reset,
   input  logic                instr_valid,
   input  cpu16_pkg::instr_t   instr,
   output logic                wb_valid,
   output cpu16_pkg::reg_idx_t wb_rd,
   output cpu16_pkg::word_t    wb_data,
   output cpu16_pkg::flags_t   flags
);

   cpu16_pkg::reg_idx_t rf_raddr_a;
   cpu16_pkg::reg_idx_t rf_raddr_b;
   cpu16_pkg::reg_idx_t rf_raddr_c;
   cpu16_pkg::word_t    rf_rdata_a;
   cpu16_pkg::word_t    rf_rdata_b;
   cpu16_pkg::word_t    rf_rdata_c;
   logic                rf_we;
   cpu16_pkg::reg_idx_t rf_waddr;
   cpu16_pkg::word_t    rf_wdata;
   logic                ex_fwd_valid;   // execute tap
   cpu16_pkg::reg_idx_t ex_fwd_rd;
   cpu16_pkg::word_t    ex_fwd_value;

   issue_if  u_issue ();    // decode to execute
   retire_if u_retire ();   // execute to writeback

   reg_file u_reg_file (
      .clk (clk), .reset (reset),
      .raddr_a (rf_raddr_a), .raddr_b (rf_raddr_b), .raddr_c (rf_raddr_c),
      .rdata_a (rf_rdata_a), .rdata_b (rf_rdata_b), .rdata_c (rf_rdata_c),
      .we (rf_we), .waddr (rf_waddr), .wdata (rf_wdata)
   );

   decode_stage u_decode (
      .clk (clk), .reset (reset), .instr_valid (instr_valid), .instr (instr),
      .rf_raddr_a (rf_raddr_a), .rf_raddr_b (rf_raddr_b), .rf_raddr_c (rf_raddr_c),
      .rf_rdata_a (rf_rdata_a), .rf_rdata_b (rf_rdata_b), .rf_rdata_c (rf_rdata_c),
      .ex_fwd_valid (ex_fwd_valid), .ex_fwd_rd (ex_fwd_rd), .ex_fwd_value (ex_fwd_value),
      .retire (u_retire.bypass), .issue (u_issue.decode)
   );

   execute_stage u_execute (
      .clk (clk), .reset (reset), .issue (u_issue.execute),
      .flags_cur (flags),   // committed flags for pass-through ops
      .ex_fwd_valid (ex_fwd_valid), .ex_fwd_rd (ex_fwd_rd), .ex_fwd_value (ex_fwd_value),
      .retire (u_retire.execute)
   );

   writeback_stage u_writeback (
      .clk (clk), .reset (reset), .retire (u_retire.writeback),
      .rf_we (rf_we), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata),
      .flags (flags), .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
   );

endmodule

`default_nettype wire

/* verification/tb_cpu16_core.sv */
// cpu16 pipeline testbench
`default_nettype none

module tb_cpu16_core;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 4;
   localparam int RANDOM_COUNT    = 400;
   localparam int DIRECTED_CYCLES = 250;   // bound on directed sends, gaps and drains
   localparam int DRAIN_LIMIT     = 10;    // two-cycle latency plus slack
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + 2 * RANDOM_COUNT + 40;

   typedef struct packed {
      cpu16_pkg::reg_idx_t rd;
      cpu16_pkg::word_t    data;
      cpu16_pkg::flags_t   fl;     // flags after this instruction
   } wb_exp_t;

   logic                clk;
   logic                reset;
   logic                instr_valid;
   cpu16_pkg::instr_t   instr;
   logic                wb_valid;
   cpu16_pkg::reg_idx_t wb_rd;
   cpu16_pkg::word_t    wb_data;
   cpu16_pkg::flags_t   flags;

   cpu16_pkg::word_t    model_regs [cpu16_pkg::NUM_REGS];   // architectural state
   cpu16_pkg::flags_t   model_flags;
   wb_exp_t             exp_q [$];                          // pending writebacks, oldest first
   wb_exp_t             cur_exp;
   integer              seed;

   cpu16_core UUT (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_valid    (wb_valid),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .flags       (flags)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(input string name, input cpu16_pkg::word_t expected,
                             input cpu16_pkg::word_t actual);
      if (actual !== expected) begin
         fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
      end
   endtask

   task automatic check_reg(input string name, input cpu16_pkg::reg_idx_t expected,
                            input cpu16_pkg::reg_idx_t actual);
      if (actual !== expected) begin
         fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
      end
   endtask

   task automatic check_flags(input string name, input cpu16_pkg::flags_t expected,
                              input cpu16_pkg::flags_t actual);
      if (actual !== expected) begin
         fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
      end
   endtask

   // one instruction against the model state, sequential semantics
   function automatic void model_exec(input cpu16_pkg::instr_t ins, output cpu16_pkg::word_t res,
                                      output cpu16_pkg::flags_t fl, output logic wr);
      logic [3:0]       op;
      logic [3:0]       imm4;     // shift amount or INC immediate
      logic [7:0]       imm8;
      cpu16_pkg::word_t a;
      cpu16_pkg::word_t b;
      cpu16_pkg::word_t old_rd;
      int               sa;
      int               sb;
      int               si;
      int               sr;
      logic             ovf;
      op     = ins.op;
      imm4   = ins.rt;
      imm8   = {ins.rs, ins.rt};
      a      = model_regs[ins.rs];   // r0 entry stays zero
      b      = model_regs[ins.rt];
      old_rd = model_regs[ins.rd];
      sa     = $signed(a);
      sb     = $signed(b);
      si     = $signed(imm4);
      sr     = 0;
      ovf    = 1'b0;
      case (op)
         4'd0: begin
            sr  = sa + sb;
            res = sr[15:0];
            ovf = (sr > 32767) || (sr < -32768);   // out of signed range
         end
         4'd1: begin
            sr  = sa - sb;
            res = sr[15:0];
            ovf = (sr > 32767) || (sr < -32768);
         end
         4'd2: res = ~(a & b);
         4'd3: res = a ^ b;
         4'd4: begin
            sr  = sa + si;
            res = sr[15:0];
            ovf = (sr > 32767) || (sr < -32768);
         end
         4'd5: begin
            sr  = sa >>> imm4;   // int keeps the sign
            res = sr[15:0];
         end
         4'd6: res = a >> imm4;
         4'd7: res = a << imm4;
         4'd8: res = {old_rd[15:8], imm8};
         4'd9: res = {imm8, old_rd[7:0]};
         default: res = '0;
      endcase
      wr = (op <= 4'd9);
      fl = model_flags;
      if (op <= 4'd4) begin
         fl.z = (res == 16'h0000);
         fl.v = ovf;
         fl.n = res[15];
      end
      model_flags = fl;
      if (wr && (ins.rd != 4'd0)) begin
         model_regs[ins.rd] = res;
      end
   endfunction

   function automatic cpu16_pkg::instr_t encode_instr(input logic [3:0] op, input logic [3:0] rd,
                                                      input logic [3:0] rs, input logic [3:0] rt);
      return cpu16_pkg::instr_t'({op, rd, rs, rt});
   endfunction

   // drive one instruction and record what it should retire
   task automatic send_instr(input cpu16_pkg::instr_t ins);
      cpu16_pkg::word_t  res;
      cpu16_pkg::flags_t fl;
      logic              wr;
      wb_exp_t           e;
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= ins;
      model_exec(ins, res, fl, wr);
      if (wr) begin
         e.rd   = ins.rd;
         e.data = res;
         e.fl   = fl;
         exp_q.push_back(e);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         instr_valid <= 1'b0;
         instr       <= '0;
      end
   endtask

   task automatic load_const(input logic [3:0] rd, input logic [15:0] value);
      send_instr(encode_instr(cpu16_pkg::OP_LLB, rd, value[7:4], value[3:0]));
      send_instr(encode_instr(cpu16_pkg::OP_LHB, rd, value[15:12], value[11:8]));   // rd dist 1
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0) && (n < DRAIN_LIMIT)) begin
         @(negedge clk);
         n++;
      end
   endtask

   // quiet pipeline, then committed flags must match the model
   task automatic end_sequence(input string name);
      idle_cycles(1);
      wait_drain();
      if (exp_q.size() != 0) begin
         fail_run($sformatf("%s: %0d writebacks did not arrive", name, exp_q.size()));
      end
      check_flags("flags", model_flags, flags);
   endtask

   task automatic build_constants();
      load_const(4'd1, 16'h7FFF);   // max positive
      load_const(4'd2, 16'h0001);
      load_const(4'd3, 16'h8000);   // min negative
      load_const(4'd4, 16'hFFFF);
      load_const(4'd5, 16'h1234);
      load_const(4'd6, 16'hA5C3);
      end_sequence("byte loads");
   endtask

   task automatic dependent_chains();
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd1, 4'd2));
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd8, 4'd7, 4'd7));    // both sources dist 1
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd10, 4'd5, 4'd6));
      send_instr(encode_instr(cpu16_pkg::OP_XOR, 4'd11, 4'd6, 4'd5));
      send_instr(encode_instr(cpu16_pkg::OP_SUB, 4'd12, 4'd2, 4'd10));  // rt dist 2
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd13, 4'd5, 4'd3));
      send_instr(encode_instr(cpu16_pkg::OP_NAND, 4'd14, 4'd1, 4'd3));
      send_instr(encode_instr(cpu16_pkg::OP_XOR, 4'd15, 4'd4, 4'd2));
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd13, 4'd13));  // dist 3, array read
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd8, 4'd2, 4'd2));
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd8, 4'd8, 4'd1));
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd9, 4'd8, 4'd8));    // younger producer wins
      send_instr(encode_instr(cpu16_pkg::OP_SLL, 4'd10, 4'd9, 4'd2));
      send_instr(encode_instr(cpu16_pkg::OP_LLB, 4'd10, 4'h5, 4'h5));   // merge into fresh rd
      end_sequence("forwarding");
   endtask

   task automatic arith_flag_cases();
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd1, 4'd2));    // positive overflow
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd3, 4'd4));    // negative overflow
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd4, 4'd2));    // carry, zero, no V
      send_instr(encode_instr(cpu16_pkg::OP_SUB, 4'd7, 4'd1, 4'd1));    // zero
      send_instr(encode_instr(cpu16_pkg::OP_SUB, 4'd7, 4'd3, 4'd2));    // negative overflow
      send_instr(encode_instr(cpu16_pkg::OP_SUB, 4'd7, 4'd1, 4'd4));    // positive overflow
      send_instr(encode_instr(cpu16_pkg::OP_SUB, 4'd7, 4'd2, 4'd5));    // plain negative
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd7, 4'd0, 4'hF));    // 0 - 1 wraps
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd7, 4'd2, 4'hF));    // back to zero
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd7, 4'd3, 4'hF));    // V on negative imm
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd7, 4'd1, 4'h1));    // V on positive imm
      send_instr(encode_instr(cpu16_pkg::OP_INC, 4'd7, 4'd5, 4'h8));    // imm -8
      end_sequence("arithmetic flags");
   endtask

   task automatic logic_and_shifts();
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd1, 4'd2));    // V and N set first
      send_instr(encode_instr(cpu16_pkg::OP_NAND, 4'd7, 4'd4, 4'd4));   // zero, V cleared
      send_instr(encode_instr(cpu16_pkg::OP_NAND, 4'd7, 4'd1, 4'd3));   // all ones
      send_instr(encode_instr(cpu16_pkg::OP_XOR, 4'd7, 4'd5, 4'd5));
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd3, 4'd4));
      send_instr(encode_instr(cpu16_pkg::OP_XOR, 4'd7, 4'd3, 4'd2));    // negative result
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd1, 4'd2));    // shifts must hold V N
      for (int sh = 0; sh < 16; sh++) begin
         send_instr(encode_instr(cpu16_pkg::OP_SRA, 4'd8, 4'd6, 4'(sh)));   // sign fill
         send_instr(encode_instr(cpu16_pkg::OP_SRL, 4'd9, 4'd4, 4'(sh)));
         send_instr(encode_instr(cpu16_pkg::OP_SLL, 4'd10, 4'd5, 4'(sh)));
      end
      send_instr(encode_instr(cpu16_pkg::OP_SRA, 4'd8, 4'd5, 4'd3));    // positive source
      end_sequence("logic and shifts");
   endtask

   task automatic zero_reg_and_nops();
      send_instr(encode_instr(cpu16_pkg::OP_LLB, 4'd0, 4'hA, 4'hB));    // still retires
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd7, 4'd0, 4'd2));    // r0 not forwarded
      send_instr(encode_instr(cpu16_pkg::OP_LHB, 4'd0, 4'hC, 4'hD));
      send_instr(encode_instr(cpu16_pkg::OP_XOR, 4'd8, 4'd0, 4'd0));
      idle_cycles(2);
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd9, 4'd0, 4'd5));
      send_instr(encode_instr(cpu16_pkg::OP_SUB, 4'd7, 4'd3, 4'd2));    // V set
      send_instr(encode_instr(4'd10, 4'd1, 4'd2, 4'd3));
      send_instr(encode_instr(4'd11, 4'd7, 4'd0, 4'd0));
      idle_cycles(1);
      send_instr(encode_instr(4'd12, 4'd1, 4'd4, 4'd4));
      send_instr(encode_instr(cpu16_pkg::OP_SRL, 4'd9, 4'd5, 4'd1));    // flags still from SUB
      send_instr(encode_instr(4'd13, 4'd7, 4'd1, 4'd1));
      send_instr(encode_instr(4'd14, 4'd2, 4'd3, 4'd4));
      idle_cycles(3);
      send_instr(encode_instr(4'd15, 4'd1, 4'd0, 4'd0));
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd11, 4'd1, 4'd0));   // r1 untouched by no-op
      send_instr(encode_instr(cpu16_pkg::OP_ADD, 4'd12, 4'd7, 4'd0));
      send_instr(encode_instr(4'd15, 4'd12, 4'd12, 4'd12));
      end_sequence("r0 and no-ops");
   endtask

   task automatic random_stream(input int count);
      integer v;
      for (int i = 0; i < count; i++) begin
         v = $random(seed);
         if (v[18:16] == 3'd0) begin
            idle_cycles(1);   // occasional bubble
         end
         send_instr(cpu16_pkg::instr_t'(v[15:0]));
      end
      end_sequence("random stream");
   endtask

   // compare process, sampled away from the driving edge
   always @(negedge clk) begin
      if (wb_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            fail_run("writeback seen while no register write was expected");
         end else begin
            cur_exp = exp_q.pop_front();
            check_reg("wb_rd", cur_exp.rd, wb_rd);
            check_word("wb_data", cur_exp.data, wb_data);
            check_flags("flags", cur_exp.fl, flags);
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      fail_run($sformatf("timeout after %0d clock cycles", WATCHDOG_CYCLES));
   end

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      seed        = 98;
      model_flags = '0;
      for (int i = 0; i < cpu16_pkg::NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_flags("flags", '0, flags);   // cleared by reset
      if (wb_valid !== 1'b0) begin
         fail_run("wb_valid is not low after reset");
      end
      build_constants();
      dependent_chains();
      arith_flag_cases();
      logic_and_shifts();
      zero_reg_and_nops();
      random_stream(RANDOM_COUNT);
      repeat (4) @(negedge clk);   // room for a stray writeback
      if (exp_q.size() != 0) begin
         fail_run($sformatf("%0d expected writebacks never appeared", exp_q.size()));
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* compile.f */
common/cpu16_pkg.sv
common/pipe_if.sv
hw/reg_file.sv
hw/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
hw/writeback_stage.sv
hw/cpu16_core.sv
verification/tb_cpu16_core.sv
